// ==== source/adc_bridge_pkg.sv ====
// ADC bridge package with shared widths, types, target states and register map constants

package adc_bridge_pkg;

    // ----------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [6:0]  i2c_addr_t;
    typedef logic [3:0]  reg_ptr_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [11:0] sample_t;
    typedef logic [4:0]  adc_channel_t;
    typedef logic [31:0] csr_word_t;

    // Bits 0..7 of a byte, then 8 for the ACK slot
    typedef logic [3:0]  bit_count_t;

    // ----------------------------------------
    // I2C target FSM
    // ----------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        DEV_ADDR,
        ADDR_ACK,
        REG_ADDR,
        WRITE_DATA,
        READ_DATA,
        IGNORE
    } target_state_t;

    // ----------------------------------------
    // Address and register map
    // ----------------------------------------
    localparam i2c_addr_t ADC_DEVICE_ADDR = 7'b1010000;

    localparam int NUM_CHANNELS = 5;

    // Stream channel numbers behind registers 1 to 5
    localparam adc_channel_t CHANNEL_ID_0 = 5'd1;
    localparam adc_channel_t CHANNEL_ID_1 = 5'd2;
    localparam adc_channel_t CHANNEL_ID_2 = 5'd3;
    localparam adc_channel_t CHANNEL_ID_3 = 5'd4;
    localparam adc_channel_t CHANNEL_ID_4 = 5'd6;

    localparam byte_t DEVICE_ID_BYTE = 8'hAF;

    // Status byte is these bits above the enable bit
    localparam logic [6:0] STATUS_FIXED_BITS = 7'b0000001;

    // Zero bits above a sample in its high byte
    localparam int SAMPLE_PAD_BITS = 4;

endpackage

// ==== source/i2c_bus_monitor.sv ====
// I2C bus monitor that synchronizes SCL and SDA and flags start, stop and SCL edges
`timescale 1ns/1ps

module i2c_bus_monitor (
    input  logic clk_core,
    input  logic reset_n,
    input  logic scl,
    input  logic sda_in,
    output logic sda_sync,
    output logic bus_start,
    output logic bus_stop,
    output logic scl_rise,
    output logic scl_fall
);

    logic [1:0] scl_meta;
    logic [1:0] sda_meta;
    logic       scl_sync;
    logic       scl_prev;
    logic       sda_prev;

    assign scl_sync = scl_meta[1];
    assign sda_sync = sda_meta[1];

    // ----------------------------------------
    // Two stage synchronizers, idle bus is high
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            scl_meta <= 2'b11;
            sda_meta <= 2'b11;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_meta <= {scl_meta[0], scl};
            sda_meta <= {sda_meta[0], sda_in};
            scl_prev <= scl_sync;
            sda_prev <= sda_sync;
        end
    end

    // ----------------------------------------
    // Registered event detection
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bus_start <= 1'b0;
            bus_stop  <= 1'b0;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
        end else begin
            // SDA moving while SCL stays high marks start or stop
            bus_start <= scl_sync && scl_prev && sda_prev && !sda_sync;
            bus_stop  <= scl_sync && scl_prev && !sda_prev && sda_sync;
            scl_rise  <= scl_sync && !scl_prev;
            scl_fall  <= !scl_sync && scl_prev;
        end
    end

endmodule

// ==== source/i2c_adc_target.sv ====
// I2C target FSM with address match, register pointer, enable bit, ACK and read shifting
`timescale 1ns/1ps

module i2c_adc_target (
    input  logic                     clk_core,
    input  logic                     reset_n,
    input  logic                     sda_sync,
    input  logic                     bus_start,
    input  logic                     bus_stop,
    input  logic                     scl_rise,
    input  logic                     scl_fall,
    input  adc_bridge_pkg::byte_t    read_byte,
    output adc_bridge_pkg::reg_ptr_t read_index,
    output logic                     adc_enable,
    output logic                     sda_drive_low
);

    adc_bridge_pkg::target_state_t state;
    adc_bridge_pkg::bit_count_t    bit_cnt;
    adc_bridge_pkg::byte_t         shift_reg;
    adc_bridge_pkg::reg_sel_t      reg_sel;
    adc_bridge_pkg::i2c_addr_t     rx_addr;
    logic                          read_mode;
    // Set after selecting register 0, cleared by the first data byte
    logic                          enable_armed;

    assign rx_addr = shift_reg[7:1];

    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            state         <= adc_bridge_pkg::IDLE;
            bit_cnt       <= '0;
            shift_reg     <= '0;
            reg_sel       <= '0;
            read_index    <= '0;
            read_mode     <= 1'b0;
            enable_armed  <= 1'b0;
            adc_enable    <= 1'b0;
            sda_drive_low <= 1'b0;
        end else if (bus_start) begin
            // Repeated start lands here as well
            state         <= adc_bridge_pkg::DEV_ADDR;
            // SCL fall after the start wraps this to zero
            bit_cnt       <= '1;
            enable_armed  <= 1'b0;
            sda_drive_low <= 1'b0;
        end else if (bus_stop) begin
            state         <= adc_bridge_pkg::IDLE;
            enable_armed  <= 1'b0;
            sda_drive_low <= 1'b0;
        end else begin
            case (state)
                // ----------------------------------------
                // Bytes from the host
                // ----------------------------------------
                adc_bridge_pkg::DEV_ADDR,
                adc_bridge_pkg::REG_ADDR,
                adc_bridge_pkg::WRITE_DATA: begin
                    if (scl_rise && bit_cnt < 4'd8) begin
                        shift_reg <= {shift_reg[6:0], sda_sync};
                    end
                    if (scl_fall) begin
                        if (bit_cnt == 4'd7) begin
                            // Eighth bit done, SCL low for the ACK slot
                            bit_cnt <= 4'd8;
                            if (state == adc_bridge_pkg::DEV_ADDR) begin
                                if (rx_addr == adc_bridge_pkg::ADC_DEVICE_ADDR) begin
                                    state         <= adc_bridge_pkg::ADDR_ACK;
                                    read_mode     <= shift_reg[0];
                                    read_index    <= {reg_sel, 1'b0};
                                    sda_drive_low <= 1'b1;
                                end else begin
                                    state <= adc_bridge_pkg::IGNORE;
                                end
                            end else begin
                                sda_drive_low <= 1'b1;
                                if (state == adc_bridge_pkg::REG_ADDR) begin
                                    reg_sel      <= shift_reg[2:0];
                                    enable_armed <= (shift_reg[2:0] == 3'd0);
                                end else if (enable_armed) begin
                                    adc_enable   <= shift_reg[0];
                                    enable_armed <= 1'b0;
                                end
                            end
                        end else if (bit_cnt == 4'd8) begin
                            // End of our ACK, later bytes are data
                            state         <= adc_bridge_pkg::WRITE_DATA;
                            bit_cnt       <= '0;
                            sda_drive_low <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end

                adc_bridge_pkg::ADDR_ACK: begin
                    if (scl_fall) begin
                        bit_cnt <= '0;
                        if (read_mode) begin
                            state         <= adc_bridge_pkg::READ_DATA;
                            shift_reg     <= read_byte;
                            read_index    <= adc_bridge_pkg::reg_ptr_t'(read_index + 4'd1);
                            sda_drive_low <= !read_byte[7];
                        end else begin
                            state         <= adc_bridge_pkg::REG_ADDR;
                            sda_drive_low <= 1'b0;
                        end
                    end
                end

                // ----------------------------------------
                // Bytes to the host, MSB first
                // ----------------------------------------
                adc_bridge_pkg::READ_DATA: begin
                    if (scl_rise && bit_cnt == 4'd8 && sda_sync) begin
                        // Host NACK, stay off the bus
                        state <= adc_bridge_pkg::IGNORE;
                    end else if (scl_fall) begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt       <= '0;
                            shift_reg     <= read_byte;
                            read_index    <= adc_bridge_pkg::reg_ptr_t'(read_index + 4'd1);
                            sda_drive_low <= !read_byte[7];
                        end else if (bit_cnt == 4'd7) begin
                            // Release for the host's ACK slot
                            bit_cnt       <= 4'd8;
                            sda_drive_low <= 1'b0;
                        end else begin
                            bit_cnt       <= bit_cnt + 4'd1;
                            shift_reg     <= {shift_reg[6:0], 1'b0};
                            sda_drive_low <= !shift_reg[6];
                        end
                    end
                end

                default: begin
                    sda_drive_low <= 1'b0;
                end
            endcase
        end
    end

    // Bus stays released outside a transaction to this target
    assert property (@(posedge clk_core) disable iff (!reset_n)
        (state inside {adc_bridge_pkg::IDLE, adc_bridge_pkg::IGNORE}) |-> !sda_drive_low);

    assert property (@(posedge clk_core) disable iff (!reset_n)
        $changed(adc_enable) |-> $past(state) == adc_bridge_pkg::WRITE_DATA);

endmodule

// ==== source/adc_sample_store.sv ====
// ADC sample store with per-channel capture, end of packet snapshot and byte read mux
`timescale 1ns/1ps

module adc_sample_store (
    input  logic                         clk_core,
    input  logic                         reset_n,
    input  logic                         adc_valid,
    input  adc_bridge_pkg::adc_channel_t adc_channel,
    input  adc_bridge_pkg::sample_t      adc_data,
    input  logic                         adc_eop,
    input  logic                         adc_enable,
    input  adc_bridge_pkg::reg_ptr_t     read_index,
    output adc_bridge_pkg::byte_t        read_byte
);

    adc_bridge_pkg::sample_t               raw_sample [adc_bridge_pkg::NUM_CHANNELS];
    adc_bridge_pkg::sample_t               vis_sample [adc_bridge_pkg::NUM_CHANNELS];
    logic [adc_bridge_pkg::NUM_CHANNELS-1:0] chan_hit;
    logic [2:0]                            chan_sel;
    adc_bridge_pkg::sample_t               sel_sample;

    // Channels outside the map leave chan_hit empty
    always_comb begin
        chan_hit = '0;
        case (adc_channel)
            adc_bridge_pkg::CHANNEL_ID_0: chan_hit[0] = 1'b1;
            adc_bridge_pkg::CHANNEL_ID_1: chan_hit[1] = 1'b1;
            adc_bridge_pkg::CHANNEL_ID_2: chan_hit[2] = 1'b1;
            adc_bridge_pkg::CHANNEL_ID_3: chan_hit[3] = 1'b1;
            adc_bridge_pkg::CHANNEL_ID_4: chan_hit[4] = 1'b1;
            default: chan_hit = '0;
        endcase
    end

    // ----------------------------------------
    // Capture and snapshot
    // ----------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < adc_bridge_pkg::NUM_CHANNELS; k++) begin
                raw_sample[k] <= '0;
                vis_sample[k] <= '0;
            end
        end else if (adc_valid) begin
            for (int k = 0; k < adc_bridge_pkg::NUM_CHANNELS; k++) begin
                if (chan_hit[k]) begin
                    raw_sample[k] <= adc_data;
                end
                // EOP beat's own sample goes straight to the visible bank
                if (adc_eop) begin
                    vis_sample[k] <= chan_hit[k] ? adc_data : raw_sample[k];
                end
            end
        end
    end

    // ----------------------------------------
    // Read map, two bytes per register
    // ----------------------------------------
    assign chan_sel = read_index[3:1] - 3'd1;

    always_comb begin
        read_byte  = '0;
        sel_sample = '0;
        case (read_index[3:1])
            3'd0: begin
                read_byte = read_index[0] ? adc_bridge_pkg::DEVICE_ID_BYTE
                                          : {adc_bridge_pkg::STATUS_FIXED_BITS, adc_enable};
            end
            3'd1, 3'd2, 3'd3, 3'd4, 3'd5: begin
                sel_sample = vis_sample[chan_sel];
                read_byte  = read_index[0]
                    ? {{adc_bridge_pkg::SAMPLE_PAD_BITS{1'b0}}, sel_sample[11:8]}
                    : sel_sample[7:0];
            end
            default: read_byte = '0;
        endcase
    end

    assert property (@(posedge clk_core) disable iff (!reset_n) adc_eop |-> adc_valid);

endmodule

// ==== source/adc_sequencer_ctrl.sv ====
// ADC sequencer control that writes a run or stop word on each change of the enable bit
`timescale 1ns/1ps

module adc_sequencer_ctrl (
    input  logic                      clk_core,
    input  logic                      reset_n,
    input  logic                      adc_enable,
    output logic                      seq_csr_write,
    output adc_bridge_pkg::csr_word_t seq_csr_writedata
);

    logic enable_q;

    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            enable_q          <= 1'b0;
            seq_csr_write     <= 1'b0;
            seq_csr_writedata <= '0;
        end else begin
            enable_q      <= adc_enable;
            seq_csr_write <= (adc_enable != enable_q);
            // Run is bit 0 set, stop is all zeros
            if (adc_enable != enable_q) begin
                seq_csr_writedata <= adc_bridge_pkg::csr_word_t'(adc_enable);
            end
        end
    end

    // Enable only moves on SCL edges, so writes never come back to back
    assert property (@(posedge clk_core) disable iff (!reset_n)
        seq_csr_write |=> !seq_csr_write);

endmodule

// ==== source/adc_bridge_top.sv ====
// ADC bridge top level joining the I2C monitor, target, sample store and sequencer control
`timescale 1ns/1ps

module adc_bridge_top (
    input  logic                         clk_core,
    input  logic                         reset_n,
    input  logic                         scl,
    input  logic                         sda_in,
    output logic                         sda_drive_low,
    input  logic                         adc_valid,
    input  adc_bridge_pkg::adc_channel_t adc_channel,
    input  adc_bridge_pkg::sample_t      adc_data,
    input  logic                         adc_eop,
    output logic                         seq_csr_write,
    output adc_bridge_pkg::csr_word_t    seq_csr_writedata
);

    logic                     sda_sync;
    logic                     bus_start;
    logic                     bus_stop;
    logic                     scl_rise;
    logic                     scl_fall;
    adc_bridge_pkg::byte_t    read_byte;
    adc_bridge_pkg::reg_ptr_t read_index;
    logic                     adc_enable;

    // ----------------------------------------
    // I2C side
    // ----------------------------------------
    i2c_bus_monitor u_bus_monitor (
        .clk_core  (clk_core),
        .reset_n   (reset_n),
        .scl       (scl),
        .sda_in    (sda_in),
        .sda_sync  (sda_sync),
        .bus_start (bus_start),
        .bus_stop  (bus_stop),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall)
    );

    i2c_adc_target u_target (
        .clk_core      (clk_core),
        .reset_n       (reset_n),
        .sda_sync      (sda_sync),
        .bus_start     (bus_start),
        .bus_stop      (bus_stop),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .read_byte     (read_byte),
        .read_index    (read_index),
        .adc_enable    (adc_enable),
        .sda_drive_low (sda_drive_low)
    );

    // ----------------------------------------
    // ADC side
    // ----------------------------------------
    adc_sample_store u_sample_store (
        .clk_core    (clk_core),
        .reset_n     (reset_n),
        .adc_valid   (adc_valid),
        .adc_channel (adc_channel),
        .adc_data    (adc_data),
        .adc_eop     (adc_eop),
        .adc_enable  (adc_enable),
        .read_index  (read_index),
        .read_byte   (read_byte)
    );

    adc_sequencer_ctrl u_sequencer_ctrl (
        .clk_core          (clk_core),
        .reset_n           (reset_n),
        .adc_enable        (adc_enable),
        .seq_csr_write     (seq_csr_write),
        .seq_csr_writedata (seq_csr_writedata)
    );

endmodule

// ==== include/i2c_host_tasks.svh ====
// I2C host bit-banging and ADC stream beat tasks for the ADC bridge testbench
`ifndef I2C_HOST_TASKS_SVH
`define I2C_HOST_TASKS_SVH

// Whole core cycles, then step past the edge before driving
task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_core);
    #(DRIVE_DELAY);
endtask

// ----------------------------------------
// Bus conditions
// ----------------------------------------
task automatic send_start();
    wait_cycles(QUARTER_CYCLES);
    sda_host = 1'b1;
    wait_cycles(QUARTER_CYCLES);
    scl = 1'b1;
    wait_cycles(QUARTER_CYCLES);
    sda_host = 1'b0;
    wait_cycles(QUARTER_CYCLES);
    scl = 1'b0;
endtask

task automatic send_stop();
    wait_cycles(QUARTER_CYCLES);
    sda_host = 1'b0;
    wait_cycles(QUARTER_CYCLES);
    scl = 1'b1;
    wait_cycles(QUARTER_CYCLES);
    sda_host = 1'b1;
    wait_cycles(QUARTER_CYCLES);
endtask

// One SCL period, data set while low and sampled mid high
task automatic clock_bit(input logic out_bit, output logic in_bit);
    wait_cycles(QUARTER_CYCLES);
    sda_host = out_bit;
    wait_cycles(QUARTER_CYCLES);
    scl = 1'b1;
    wait_cycles(QUARTER_CYCLES);
    in_bit = sda_line;
    wait_cycles(QUARTER_CYCLES);
    scl = 1'b0;
endtask

// ----------------------------------------
// Bytes
// ----------------------------------------
task automatic write_bus_byte(input adc_bridge_pkg::byte_t data, output logic acked);
    logic echo;
    logic ack_bit;
    for (int i = 7; i >= 0; i--) begin
        clock_bit(data[i], echo);
    end
    clock_bit(1'b1, ack_bit);
    acked = !ack_bit;
endtask

task automatic read_bus_byte(input logic ack, output adc_bridge_pkg::byte_t data);
    logic b;
    logic echo;
    data = '0;
    for (int i = 0; i < 8; i++) begin
        clock_bit(1'b1, b);
        data = {data[6:0], b};
    end
    // Low for ACK, released for NACK
    clock_bit(!ack, echo);
endtask

// Single beat on the ADC stream
task automatic stream_beat(input adc_bridge_pkg::adc_channel_t channel,
                           input adc_bridge_pkg::sample_t data, input logic eop);
    adc_valid   = 1'b1;
    adc_channel = channel;
    adc_data    = data;
    adc_eop     = eop;
    wait_cycles(1);
    adc_valid   = 1'b0;
    adc_eop     = 1'b0;
endtask

`endif

// ==== bench/tb_adc_bridge.sv ====
// Testbench for the ADC bridge with an I2C host, an ADC stream source and checkers
`timescale 1ns/1ps

module tb_adc_bridge;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int QUARTER_CYCLES = 10;
    // Bus bytes over all tests, start and stop included
    localparam int BUS_BYTES      = 80;
    localparam int BYTE_NS        = 9 * 4 * QUARTER_CYCLES * CLK_PERIOD;
    localparam int WATCHDOG_NS    = 2 * BUS_BYTES * BYTE_NS;
    localparam logic [6:0] TARGET_ADDR = 7'b1010000;

    logic                         clk_core;
    logic                         reset_n;
    logic                         scl;
    logic                         sda_host;
    wire                          sda_line;
    logic                         sda_drive_low;
    logic                         adc_valid;
    adc_bridge_pkg::adc_channel_t adc_channel;
    adc_bridge_pkg::sample_t      adc_data;
    logic                         adc_eop;
    logic                         seq_csr_write;
    adc_bridge_pkg::csr_word_t    seq_csr_writedata;

    logic        cmp_strobe;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;
    string       cmp_what;
    logic        quiet_bus;
    logic        exp_enable;
    int          pulse_count;
    int          check_count;
    int          mismatches;
    int          other_errors;

    // Reference model of the register map
    logic                         model_enable;
    adc_bridge_pkg::sample_t      model_samples [5];
    adc_bridge_pkg::sample_t      next_samples [5];
    adc_bridge_pkg::adc_channel_t channel_ids [5];

    // Wired-AND of host and target
    assign sda_line = sda_host & ~sda_drive_low;

    initial clk_core = 1'b0;
    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    adc_bridge_top u_dut (
        .clk_core          (clk_core),
        .reset_n           (reset_n),
        .scl               (scl),
        .sda_in            (sda_line),
        .sda_drive_low     (sda_drive_low),
        .adc_valid         (adc_valid),
        .adc_channel       (adc_channel),
        .adc_data          (adc_data),
        .adc_eop           (adc_eop),
        .seq_csr_write     (seq_csr_write),
        .seq_csr_writedata (seq_csr_writedata)
    );

    `include "i2c_host_tasks.svh"

    always @(posedge clk_core) begin
        if (seq_csr_write) begin
            pulse_count = pulse_count + 1;
        end
    end

    // ----------------------------------------
    // Checkers
    // ----------------------------------------
    assert property (@(posedge clk_core) cmp_strobe |-> cmp_got == cmp_exp)
    else begin
        mismatches++;
        $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                 $time, cmp_what, cmp_got, cmp_exp);
    end

    assert property (@(posedge clk_core) disable iff (!reset_n)
        seq_csr_write |-> seq_csr_writedata == {31'd0, exp_enable})
    else begin
        mismatches++;
        $display("Mismatch at %0t ns: sequencer word 0x%0h, expected 0x%0h",
                 $time, seq_csr_writedata, {31'd0, exp_enable});
    end

    assert property (@(posedge clk_core) quiet_bus |-> !sda_drive_low)
    else begin
        other_errors++;
        $display("Error at %0t ns: the target pulled SDA low while it should stay off the bus",
                 $time);
    end

    assert property (@(posedge clk_core) !reset_n |-> !sda_drive_low && !seq_csr_write)
    else begin
        other_errors++;
        $display("Error at %0t ns: SDA pull-down or sequencer write active in reset", $time);
    end

    // ----------------------------------------
    // Test helpers
    // ----------------------------------------
    function automatic adc_bridge_pkg::byte_t expected_map_byte(input int index);
        adc_bridge_pkg::sample_t s;
        if (index == 0) begin
            return {7'b0000001, model_enable};
        end else if (index == 1) begin
            return 8'hAF;
        end else if (index < 12) begin
            s = model_samples[index / 2 - 1];
            return (index % 2 == 0) ? s[7:0] : {4'b0000, s[11:8]};
        end
        return 8'h00;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        cmp_got    = got;
        cmp_exp    = exp;
        cmp_what   = what;
        cmp_strobe = 1'b1;
        check_count++;
        wait_cycles(1);
        cmp_strobe = 1'b0;
    endtask

    task automatic select_register(input int r);
        logic acked;
        send_start();
        write_bus_byte({TARGET_ADDR, 1'b0}, acked);
        compare_value(32'(acked), 1, "address ACK");
        write_bus_byte(8'(r), acked);
        compare_value(32'(acked), 1, "register ACK");
        send_stop();
    endtask

    task automatic write_enable(input logic value);
        int   pulses_before;
        logic acked;
        exp_enable    = value;
        model_enable  = value;
        pulses_before = pulse_count;
        send_start();
        write_bus_byte({TARGET_ADDR, 1'b0}, acked);
        write_bus_byte(8'h00, acked);
        write_bus_byte({7'd0, value}, acked);
        compare_value(32'(acked), 1, "enable byte ACK");
        send_stop();
        compare_value(pulse_count - pulses_before, 1, "sequencer write count");
    endtask

    // Host NACKs the last byte, then the target must leave SDA alone
    task automatic read_and_check(input int r, input int count);
        logic                  acked;
        adc_bridge_pkg::byte_t data;
        select_register(r);
        send_start();
        write_bus_byte({TARGET_ADDR, 1'b1}, acked);
        compare_value(32'(acked), 1, "read address ACK");
        for (int i = 0; i < count; i++) begin
            read_bus_byte(i < count - 1, data);
            if (i == count - 1) begin
                quiet_bus = 1'b1;
            end
            compare_value(32'(data), 32'(expected_map_byte((2 * r + i) % 16)),
                          $sformatf("register %0d byte %0d", r, i));
        end
        send_stop();
        quiet_bus = 1'b0;
    endtask

    task automatic probe_other_address(input logic [6:0] addr, input logic rw);
        logic acked;
        quiet_bus = 1'b1;
        send_start();
        write_bus_byte({addr, rw}, acked);
        compare_value(32'(acked), 0, $sformatf("ACK from address 0x%0h", addr));
        send_stop();
        quiet_bus = 1'b0;
    endtask

    // Mapped channels plus a decoy on channel 5
    task automatic stream_samples(input logic eop_last);
        for (int k = 0; k < 4; k++) begin
            stream_beat(channel_ids[k], next_samples[k], 1'b0);
        end
        stream_beat(5'd5, 12'($urandom), 1'b0);
        stream_beat(channel_ids[4], next_samples[4], eop_last);
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reset_n      = 1'b0;
        scl          = 1'b1;
        sda_host     = 1'b1;
        adc_valid    = 1'b0;
        adc_channel  = '0;
        adc_data     = '0;
        adc_eop      = 1'b0;
        cmp_strobe   = 1'b0;
        cmp_got      = '0;
        cmp_exp      = '0;
        cmp_what     = "";
        quiet_bus    = 1'b0;
        exp_enable   = 1'b0;
        pulse_count  = 0;
        check_count  = 0;
        mismatches   = 0;
        other_errors = 0;
        model_enable = 1'b0;
        channel_ids  = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd6};
        for (int k = 0; k < 5; k++) begin
            model_samples[k] = '0;
        end
        void'($urandom(32'hb2db7cbf));
        repeat (5) @(posedge clk_core);
        #(DRIVE_DELAY);
        reset_n = 1'b1;
        wait_cycles(4);

        // Status and ID out of reset
        read_and_check(0, 2);

        write_enable(1'b1);
        read_and_check(0, 1);
        write_enable(1'b0);
        read_and_check(0, 1);

        // Full packet closed by end of packet
        for (int k = 0; k < 5; k++) begin
            next_samples[k] = 12'($urandom);
        end
        stream_samples(1'b1);
        model_samples = next_samples;
        read_and_check(1, 10);

        // No end of packet, old snapshot stays
        for (int k = 0; k < 5; k++) begin
            next_samples[k] = 12'($urandom);
        end
        stream_samples(1'b0);
        read_and_check(1, 10);
        next_samples[4] = 12'($urandom);
        stream_beat(channel_ids[4], next_samples[4], 1'b1);
        model_samples = next_samples;
        read_and_check(1, 10);

        probe_other_address(7'b1010001, 1'b0);
        probe_other_address(7'b0010000, 1'b1);

        // Beyond the map, with wrap back to the status byte
        read_and_check(6, 5);
        read_and_check(6, 1);

        wait_cycles(QUARTER_CYCLES);
        finish_run();
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        finish_run();
    end

endmodule

// ==== adc_bridge.f ====
+incdir+include
source/adc_bridge_pkg.sv
source/i2c_bus_monitor.sv
source/i2c_adc_target.sv
source/adc_sample_store.sv
source/adc_sequencer_ctrl.sv
source/adc_bridge_top.sv
bench/tb_adc_bridge.sv

// ==== Makefile ====
# Verilator lint, simulation and clean targets for the ADC bridge

VERILATOR ?= verilator
TOP       ?= tb_adc_bridge
FILELIST  ?= adc_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed
VL_FLAGS  ?= --timing --assert

SOURCES := $(FILELIST) $(wildcard source/*.sv bench/*.sv include/*.svh)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VL_FLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary $(VL_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
